/* hw/apb_regs.sv */
//--------------------------------------
// apb slave for STEP, POS and STATUS
// no wait states, PREADY tied high
// step is combinational, high only in the
// access cycle of a STEP write
//--------------------------------------
module apb_regs (
	input  logic                              Clk,
	input  logic                              Reset,
	input  logic                              PSEL,
	input  logic                              PENABLE,
	input  logic                              PWRITE,
	input  logic [3:0]                        PADDR,
	input  logic [31:0]                       PWDATA,
	output logic [31:0]                       PRDATA,
	output logic                              PREADY,
	output logic                              PSLVERR,
	input  logic [platform_pkg::COORD_W-1:0]  pos_x,
	input  logic [platform_pkg::COORD_W-1:0]  pos_y,
	input  platform_pkg::move_state_e         state,
	input  logic                              on_ground,
	input  logic [3:0]                        fall_speed,
	output logic                              step,
	output platform_pkg::key_cmd_e            step_key
);

	logic access;
	logic addr_ok;
	logic is_step;

	// access phase of a transfer
	assign access = PSEL && PENABLE;
	assign addr_ok = (PADDR == platform_pkg::ADDR_STEP) ||
	                 (PADDR == platform_pkg::ADDR_POS) ||
	                 (PADDR == platform_pkg::ADDR_STATUS);
	assign is_step = PADDR == platform_pkg::ADDR_STEP;

	assign PREADY = 1'b1;
	// bad address, or write to a read-only reg
	assign PSLVERR = access && (!addr_ok || (PWRITE && !is_step));

	// frame advance
	assign step = access && PWRITE && is_step;
	assign step_key = platform_pkg::key_decode(PWDATA);

	// read mux
	always_comb begin
		PRDATA = '0;
		if (access && !PWRITE) begin
			case (PADDR)
				platform_pkg::ADDR_POS:
					PRDATA = {6'd0, pos_y, 6'd0, pos_x};
				platform_pkg::ADDR_STATUS:
					PRDATA = {24'd0, fall_speed, 1'b0, on_ground, state};
				default:
					PRDATA = '0;
			endcase
		end
	end

	// a step pulse sits in an access cycle that followed a write setup
	a_step_in_access: assert property (@(posedge Clk) disable iff (Reset)
		step |-> PSEL && PENABLE && $past(PSEL && !PENABLE && PWRITE));

endmodule

/* hw/collision_probe.sv */
//--------------------------------------
// combinational collision probe
// samples the box corners against the tile map
// every pixel between start and end is scanned
// so a move can never skip through a tile
//--------------------------------------
module collision_probe (
	input  logic [platform_pkg::COORD_W-1:0]  pos_x,
	input  logic [platform_pkg::COORD_W-1:0]  pos_y,
	output logic                              on_ground,
	output logic [3:0]                        fall_step,
	output logic [2:0]                        rise_step,
	output logic [1:0]                        left_move,
	output logic [1:0]                        right_move
);

	// box edges
	logic [platform_pkg::COORD_W-1:0] col_r;
	logic [platform_pkg::COORD_W-1:0] col_l;
	logic [platform_pkg::COORD_W-1:0] row_bot;
	logic [platform_pkg::COORD_W-1:0] row_top;

	assign col_r = pos_x;
	assign col_l = pos_x - platform_pkg::COORD_W'(platform_pkg::CHAR_W - 1);
	assign row_bot = pos_y;
	assign row_top = pos_y - platform_pkg::COORD_W'(platform_pkg::CHAR_H - 1);

	// solid right under either foot
	assign on_ground = platform_pkg::tile_solid(col_l, row_bot + 1'b1) ||
	                   platform_pkg::tile_solid(col_r, row_bot + 1'b1);

	// ---------------------------------------
	// vertical scans
	// ---------------------------------------
	always_comb begin : fall_scan
		logic clear;
		logic [platform_pkg::COORD_W-1:0] row;
		clear = 1'b1;
		fall_step = 4'd0;
		for (int k = 1; k <= platform_pkg::FALL_SNAP_MAX; k++) begin
			row = row_bot + platform_pkg::COORD_W'(k);
			clear = clear && !platform_pkg::tile_solid(col_l, row) &&
			        !platform_pkg::tile_solid(col_r, row);
			if (clear)
				fall_step = 4'(k);
		end
	end

	always_comb begin : rise_scan
		logic clear;
		logic [platform_pkg::COORD_W-1:0] row;
		clear = 1'b1;
		rise_step = 3'd0;
		for (int k = 1; k <= platform_pkg::RISE_STEP; k++) begin
			row = row_top - platform_pkg::COORD_W'(k);
			clear = clear && !platform_pkg::tile_solid(col_l, row) &&
			        !platform_pkg::tile_solid(col_r, row);
			if (clear)
				rise_step = 3'(k);
		end
	end

	// ---------------------------------------
	// horizontal scans, top and bottom rows
	// ---------------------------------------
	always_comb begin : left_scan
		logic clear;
		logic [platform_pkg::COORD_W-1:0] col;
		clear = 1'b1;
		left_move = 2'd0;
		for (int m = 1; m <= platform_pkg::RUN_MAX; m++) begin
			col = col_l - platform_pkg::COORD_W'(m);
			clear = clear && !platform_pkg::tile_solid(col, row_bot) &&
			        !platform_pkg::tile_solid(col, row_top);
			if (clear)
				left_move = 2'(m);
		end
	end

	always_comb begin : right_scan
		logic clear;
		logic [platform_pkg::COORD_W-1:0] col;
		clear = 1'b1;
		right_move = 2'd0;
		for (int m = 1; m <= platform_pkg::RUN_MAX; m++) begin
			col = col_r + platform_pkg::COORD_W'(m);
			clear = clear && !platform_pkg::tile_solid(col, row_bot) &&
			        !platform_pkg::tile_solid(col, row_top);
			if (clear)
				right_move = 2'(m);
		end
	end

endmodule

/* hw/motion_ctrl.sv */
//--------------------------------------
// character motion FSM
// advances exactly one frame per step pulse
// probe inputs must reflect the current position
// jump only starts from GROUNDED
//--------------------------------------
module motion_ctrl (
	input  logic                              Clk,
	input  logic                              Reset,
	input  logic                              step,
	input  platform_pkg::key_cmd_e            step_key,
	input  logic                              on_ground,
	input  logic [3:0]                        fall_step,
	input  logic [2:0]                        rise_step,
	input  logic [1:0]                        left_move,
	input  logic [1:0]                        right_move,
	output logic [platform_pkg::COORD_W-1:0]  pos_x,
	output logic [platform_pkg::COORD_W-1:0]  pos_y,
	output platform_pkg::move_state_e         state,
	output logic [3:0]                        fall_speed
);

	logic [platform_pkg::COORD_W-1:0] x_next;
	logic [platform_pkg::COORD_W-1:0] y_next;
	platform_pkg::move_state_e state_next;
	logic [3:0] speed_next;
	logic [3:0] speed_inc;
	logic [3:0] drop;
	logic [3:0] rise_cnt;
	logic [3:0] rise_cnt_next;
	logic jump_key;

	assign jump_key = step_key inside {platform_pkg::KEY_W, platform_pkg::KEY_WA,
	                                   platform_pkg::KEY_WD};

	// gravity, saturating at terminal speed
	assign speed_inc = (fall_speed >= 4'(platform_pkg::FALL_MAX)) ?
	                   4'(platform_pkg::FALL_MAX) : fall_speed + 4'd1;
	// never drop further than the probe says is clear
	assign drop = (speed_inc < fall_step) ? speed_inc : fall_step;

	// ---------------------------------------
	// next frame
	// ---------------------------------------
	always_comb begin
		x_next = pos_x;
		y_next = pos_y;
		state_next = state;
		speed_next = fall_speed;
		rise_cnt_next = rise_cnt;

		// horizontal first
		case (step_key)
			platform_pkg::KEY_A, platform_pkg::KEY_WA:
				x_next = pos_x - platform_pkg::COORD_W'(left_move);
			platform_pkg::KEY_D, platform_pkg::KEY_WD:
				x_next = pos_x + platform_pkg::COORD_W'(right_move);
			default:
				x_next = pos_x;
		endcase

		case (state)
			platform_pkg::GROUNDED: begin
				if (jump_key) begin
					state_next = platform_pkg::RISING;
					rise_cnt_next = 4'(platform_pkg::RISE_FRAMES);
				end else if (!on_ground) begin
					// walked off an edge
					state_next = platform_pkg::FALLING;
					speed_next = 4'd0;
				end
			end
			platform_pkg::RISING: begin
				y_next = pos_y - platform_pkg::COORD_W'(rise_step);
				rise_cnt_next = rise_cnt - 4'd1;
				// head hit or jump used up
				if (rise_step == 3'd0 || rise_cnt_next == 4'd0) begin
					state_next = platform_pkg::FALLING;
					speed_next = 4'd0;
				end
			end
			default: begin
				if (on_ground) begin
					state_next = platform_pkg::GROUNDED;
					speed_next = 4'd0;
				end else begin
					speed_next = speed_inc;
					y_next = pos_y + platform_pkg::COORD_W'(drop);
				end
			end
		endcase
	end

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			pos_x <= platform_pkg::COORD_W'(platform_pkg::START_X);
			pos_y <= platform_pkg::COORD_W'(platform_pkg::START_Y);
			state <= platform_pkg::FALLING;
			fall_speed <= 4'd0;
			rise_cnt <= 4'd0;
		end else if (step) begin
			pos_x <= x_next;
			pos_y <= y_next;
			state <= state_next;
			fall_speed <= speed_next;
			rise_cnt <= rise_cnt_next;
		end
	end

	a_state_legal: assert property (@(posedge Clk) disable iff (Reset)
		state inside {platform_pkg::GROUNDED, platform_pkg::RISING, platform_pkg::FALLING});

	a_fall_capped: assert property (@(posedge Clk) disable iff (Reset)
		fall_speed <= 4'(platform_pkg::FALL_MAX));

endmodule

/* hw/pixel_shader.sv */
//--------------------------------------
// pixel colour, one cycle latency
// character drawn as a flat box over the map
// blank is active low
//--------------------------------------
module pixel_shader (
	input  logic                              Clk,
	input  logic                              Reset,
	input  logic [9:0]                        DrawX,
	input  logic [9:0]                        DrawY,
	input  logic                              blank,
	input  logic [platform_pkg::COORD_W-1:0]  pos_x,
	input  logic [platform_pkg::COORD_W-1:0]  pos_y,
	output logic [23:0]                       rgb
);

	logic [platform_pkg::COORD_W-1:0] box_left;
	logic [platform_pkg::COORD_W-1:0] box_top;
	logic in_box;

	// box spans x-25..x and y-31..y
	assign box_left = pos_x - platform_pkg::COORD_W'(platform_pkg::CHAR_W - 1);
	assign box_top = pos_y - platform_pkg::COORD_W'(platform_pkg::CHAR_H - 1);
	assign in_box = (DrawX >= box_left) && (DrawX <= pos_x) &&
	                (DrawY >= box_top) && (DrawY <= pos_y);

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			rgb <= platform_pkg::RGB_BLANK;
		end else if (!blank) begin
			rgb <= platform_pkg::RGB_BLANK;
		end else if (in_box) begin
			// character wins over tiles
			rgb <= platform_pkg::RGB_CHAR;
		end else if (platform_pkg::tile_solid(DrawX, DrawY)) begin
			rgb <= platform_pkg::RGB_SOLID;
		end else begin
			rgb <= platform_pkg::RGB_SKY;
		end
	end

endmodule

/* hw/platform_pkg.sv */
//--------------------------------------
// shared constants, enums and the fixed tile map
// positions are the bottom-right pixel of the box
// anything outside the 20x15 map reads as solid, so
// coordinates that wrap below zero are solid too
//--------------------------------------
package platform_pkg;

	// ---------------------------------------
	// geometry
	// ---------------------------------------
	localparam int COORD_W    = 10;
	// 32 px tiles
	localparam int TILE_SHIFT = 5;
	localparam int MAP_ROWS   = 15;
	localparam int MAP_COLS   = 20;
	localparam int CHAR_W     = 26;
	localparam int CHAR_H     = 32;
	localparam int START_X    = 30;
	localparam int START_Y    = 33;

	// motion limits, px per frame
	localparam int FALL_MAX      = 6;
	localparam int FALL_SNAP_MAX = 5;
	localparam int RISE_STEP     = 4;
	localparam int RISE_FRAMES   = 8;
	localparam int RUN_MAX       = 2;

	// decoded keys
	// A=0x04, D=0x07, W=0x1A, pairs in either byte order
	typedef enum logic [2:0] {
		KEY_NONE,
		KEY_A,
		KEY_D,
		KEY_W,
		KEY_WA,
		KEY_WD
	} key_cmd_e;

	typedef enum logic [1:0] {
		GROUNDED,
		RISING,
		FALLING
	} move_state_e;

	// apb register offsets
	localparam logic [3:0] ADDR_STEP   = 4'h0;
	localparam logic [3:0] ADDR_POS    = 4'h4;
	localparam logic [3:0] ADDR_STATUS = 4'h8;

	// 24-bit rgb
	localparam logic [23:0] RGB_SKY   = 24'h00007F;
	localparam logic [23:0] RGB_SOLID = 24'h000050;
	localparam logic [23:0] RGB_CHAR  = 24'hFF5500;
	localparam logic [23:0] RGB_BLANK = 24'h000000;

	// ---------------------------------------
	// tile map lookup, pixel coordinates in
	// ---------------------------------------
	function automatic logic tile_solid(input logic [COORD_W-1:0] px,
	                                    input logic [COORD_W-1:0] py);
		logic [COORD_W-TILE_SHIFT-1:0] col;
		logic [COORD_W-TILE_SHIFT-1:0] row;
		col = px[COORD_W-1:TILE_SHIFT];
		row = py[COORD_W-1:TILE_SHIFT];
		// off the map
		if (col >= MAP_COLS || row >= MAP_ROWS)
			return 1'b1;
		// floor
		if (row >= 11)
			return 1'b1;
		// stepped block
		if (row == 10 && col >= 14 && col <= 17)
			return 1'b1;
		if (row == 9 && (col == 15 || col == 16))
			return 1'b1;
		// floating pillar
		if ((row == 6 || row == 7) && col == 12)
			return 1'b1;
		return 1'b0;
	endfunction

	// raw keyboard word to command
	function automatic key_cmd_e key_decode(input logic [31:0] data);
		case (data)
			32'h0000_0004:                return KEY_A;
			32'h0000_0007:                return KEY_D;
			32'h0000_001A:                return KEY_W;
			32'h0000_1A04, 32'h0000_041A: return KEY_WA;
			32'h0000_1A07, 32'h0000_071A: return KEY_WD;
			default:                      return KEY_NONE;
		endcase
	endfunction

endpackage

/* hw/platform_top.sv */
//--------------------------------------
// platform game top level
// apb host side advances frames
// pixel side runs in parallel, never stalled
//--------------------------------------
module platform_top (
	input  logic        Clk,
	input  logic        Reset,
	input  logic        PSEL,
	input  logic        PENABLE,
	input  logic        PWRITE,
	input  logic [3:0]  PADDR,
	input  logic [31:0] PWDATA,
	output logic [31:0] PRDATA,
	output logic        PREADY,
	output logic        PSLVERR,
	input  logic [9:0]  DrawX,
	input  logic [9:0]  DrawY,
	input  logic        blank,
	output logic [23:0] rgb
);

	// step path
	logic step;
	platform_pkg::key_cmd_e step_key;

	// character state
	logic [platform_pkg::COORD_W-1:0] pos_x;
	logic [platform_pkg::COORD_W-1:0] pos_y;
	platform_pkg::move_state_e state;
	logic [3:0] fall_speed;

	// probe results
	logic on_ground;
	logic [3:0] fall_step;
	logic [2:0] rise_step;
	logic [1:0] left_move;
	logic [1:0] right_move;

	apb_regs u_apb_regs (
		.Clk(Clk), .Reset(Reset),
		.PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
		.PADDR(PADDR), .PWDATA(PWDATA),
		.PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
		.pos_x(pos_x), .pos_y(pos_y), .state(state),
		.on_ground(on_ground), .fall_speed(fall_speed),
		.step(step), .step_key(step_key)
	);

	motion_ctrl u_motion_ctrl (
		.Clk(Clk), .Reset(Reset),
		.step(step), .step_key(step_key),
		.on_ground(on_ground), .fall_step(fall_step), .rise_step(rise_step),
		.left_move(left_move), .right_move(right_move),
		.pos_x(pos_x), .pos_y(pos_y), .state(state), .fall_speed(fall_speed)
	);

	collision_probe u_collision_probe (
		.pos_x(pos_x), .pos_y(pos_y),
		.on_ground(on_ground), .fall_step(fall_step), .rise_step(rise_step),
		.left_move(left_move), .right_move(right_move)
	);

	pixel_shader u_pixel_shader (
		.Clk(Clk), .Reset(Reset),
		.DrawX(DrawX), .DrawY(DrawY), .blank(blank),
		.pos_x(pos_x), .pos_y(pos_y),
		.rgb(rgb)
	);

endmodule

/* run.sh */
#!/bin/sh
# build with Verilator from the project root, run, and judge the result by the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module platform_tb -f vlog.f &&
./obj_dir/Vplatform_tb | tee /dev/stderr | grep -q "Test completed successfully" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* tests/platform_tb.sv */
//----------------------------------------
// testbench for platform_top
// run from the project root, vectors come from
// tests/platform_vectors.txt
// the last vector position is reused for the pixel checks
// stops at the first mismatch
//----------------------------------------
module platform_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int APB_TIMEOUT = 16;

	logic        Clk;
	logic        Reset;
	logic        PSEL;
	logic        PENABLE;
	logic        PWRITE;
	logic [3:0]  PADDR;
	logic [31:0] PWDATA;
	logic [31:0] PRDATA;
	logic        PREADY;
	logic        PSLVERR;
	logic [9:0]  DrawX;
	logic [9:0]  DrawY;
	logic        blank;
	logic [23:0] rgb;

	int          errors;
	logic [31:0] seed;

	platform_top u_platform_top (
		.Clk(Clk), .Reset(Reset),
		.PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
		.PADDR(PADDR), .PWDATA(PWDATA),
		.PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
		.DrawX(DrawX), .DrawY(DrawY), .blank(blank), .rgb(rgb)
	);

	// 4 ns clock
	initial begin
		Clk = 1'b0;
		forever #2 Clk = ~Clk;
	end

	// ----------------------------------------
	// reporting and checks
	// ----------------------------------------
	task automatic stop_run(input string what);
		errors++;
		$display("%s", what);
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		assert (expected == actual) else
			stop_run($sformatf("error %s expected %0d actual %0d", name, expected, actual));
	endtask

	task automatic check_rgb(input string name, input logic [23:0] expected,
	                         input logic [23:0] actual);
		assert (expected === actual) else
			stop_run($sformatf("error %s expected %06h actual %06h", name, expected, actual));
	endtask

	// ----------------------------------------
	// APB transfers, driven on the falling edge
	// ----------------------------------------
	task automatic apb_transfer(input logic write, input logic [3:0] addr,
	                            input logic [31:0] wdata, output logic [31:0] rdata,
	                            output logic slverr);
		int waits;
		// setup cycle
		@(negedge Clk);
		PSEL = 1'b1;
		PENABLE = 1'b0;
		PWRITE = write;
		PADDR = addr;
		PWDATA = wdata;
		// access cycle
		@(negedge Clk);
		PENABLE = 1'b1;
		#1;
		waits = 0;
		while (!PREADY) begin
			if (waits == APB_TIMEOUT)
				stop_run("timeout waiting for PREADY");
			@(negedge Clk);
			#1;
			waits++;
		end
		// sampled mid low phase, before the closing edge
		rdata = PRDATA;
		slverr = PSLVERR;
		@(negedge Clk);
		PSEL = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
	                         output logic slverr);
		logic [31:0] discard;
		apb_transfer(1'b1, addr, data, discard, slverr);
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
	                        output logic slverr);
		apb_transfer(1'b0, addr, 32'd0, data, slverr);
	endtask

	// POS and STATUS against expected x, y, state, fall speed
	task automatic check_state(input string name, input int ex, input int ey,
	                           input int est, input int espd);
		logic [31:0] d;
		logic err;
		logic want_ground;
		// ground contact from the map under both bottom corners
		want_ground = solid_at(ex - 25, ey + 1) || solid_at(ex, ey + 1);
		apb_read(platform_pkg::ADDR_POS, d, err);
		check_value({name, " pos slverr"}, 0, err);
		check_value({name, " x"}, ex, d[9:0]);
		check_value({name, " y"}, ey, d[25:16]);
		apb_read(platform_pkg::ADDR_STATUS, d, err);
		check_value({name, " status slverr"}, 0, err);
		check_value({name, " state"}, est, d[1:0]);
		check_value({name, " ground"}, want_ground, d[2]);
		check_value({name, " fall speed"}, espd, d[7:4]);
	endtask

	// ----------------------------------------
	// scene model for the pixel checks
	// ----------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// map in pixel ranges, off-map counts as solid
	function automatic logic solid_at(input int x, input int y);
		if (x < 0 || y < 0 || x >= 640 || y >= 352)
			return 1'b1;
		if (y >= 320 && x >= 448 && x <= 575)
			return 1'b1;
		if (y >= 288 && y <= 319 && x >= 480 && x <= 543)
			return 1'b1;
		// pillar at column 12
		if (y >= 192 && y <= 255 && x >= 384 && x <= 415)
			return 1'b1;
		return 1'b0;
	endfunction

	function automatic logic [23:0] expected_rgb(input int x, input int y, input int cx,
	                                             input int cy, input logic vis);
		if (!vis)
			return platform_pkg::RGB_BLANK;
		if (x >= cx - 25 && x <= cx && y >= cy - 31 && y <= cy)
			return platform_pkg::RGB_CHAR;
		if (solid_at(x, y))
			return platform_pkg::RGB_SOLID;
		return platform_pkg::RGB_SKY;
	endfunction

	// new pixel each falling edge, previous one checked on the same edge
	task automatic pixel_sweep(input int count, input logic vis, input int cx, input int cy);
		logic [23:0] want;
		logic pending;
		int x;
		int y;
		int px;
		int py;
		pending = 1'b0;
		for (int i = 0; i < count; i++) begin
			@(negedge Clk);
			if (pending)
				check_rgb($sformatf("pixel %0d,%0d", px, py), want, rgb);
			seed = xorshift(seed);
			// every fourth pixel lands around the box
			if (i % 4 == 0) begin
				x = (cx - 30 + int'(seed % 36)) & 1023;
				y = (cy - 36 + int'((seed >> 12) % 44)) & 1023;
			end else begin
				x = int'(seed % 680);
				y = int'((seed >> 12) % 520);
			end
			DrawX = x[9:0];
			DrawY = y[9:0];
			blank = vis;
			want = expected_rgb(x, y, cx, cy, vis);
			px = x;
			py = y;
			pending = 1'b1;
		end
		@(negedge Clk);
		check_rgb($sformatf("pixel %0d,%0d", px, py), want, rgb);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin : main
		int fd;
		int n;
		int line_no;
		int vec_count;
		int steps;
		int ex;
		int ey;
		int est;
		int espd;
		int last_x;
		int last_y;
		int last_st;
		int last_spd;
		string line;
		logic [31:0] key;
		logic [31:0] d;
		logic err;

		PSEL = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		PADDR = 4'd0;
		PWDATA = 32'd0;
		DrawX = 10'd0;
		DrawY = 10'd0;
		// visible sky pixel while reset holds rgb at zero
		blank = 1'b1;
		Reset = 1'b1;
		errors = 0;
		seed = 32'h9b5f;
		vec_count = 0;
		line_no = 0;

		repeat (10) @(negedge Clk);
		Reset = 1'b0;

		// reset values
		check_rgb("reset rgb", platform_pkg::RGB_BLANK, rgb);
		check_state("reset", 30, 33, 2, 0);

		fd = $fopen("tests/platform_vectors.txt", "r");
		if (fd == 0)
			stop_run("could not open tests/platform_vectors.txt");
		while ($fgets(line, fd) != 0) begin
			line_no++;
			// comments and blank lines
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%h %d %d %d %d %d", key, steps, ex, ey, est, espd);
			if (n != 6)
				stop_run($sformatf("vector line %0d could not be parsed", line_no));
			for (int s = 0; s < steps; s++) begin
				apb_write(platform_pkg::ADDR_STEP, key, err);
				check_value($sformatf("vector line %0d step slverr", line_no), 0, err);
			end
			check_state($sformatf("vector line %0d", line_no), ex, ey, est, espd);
			last_x = ex;
			last_y = ey;
			last_st = est;
			last_spd = espd;
			vec_count++;
		end
		$fclose(fd);
		assert (vec_count > 0) else
			stop_run("the vector file held no vectors");

		// pixels, visible then blanked
		pixel_sweep(200, 1'b1, last_x, last_y);
		pixel_sweep(40, 1'b0, last_x, last_y);

		// bad accesses flag PSLVERR and change nothing
		apb_write(platform_pkg::ADDR_POS, 32'h0010_0010, err);
		check_value("pos write slverr", 1, err);
		apb_write(platform_pkg::ADDR_STATUS, 32'h0000_0001, err);
		check_value("status write slverr", 1, err);
		apb_read(4'hC, d, err);
		check_value("addr c read slverr", 1, err);
		apb_write(4'hC, 32'h0000_0007, err);
		check_value("addr c write slverr", 1, err);
		check_state("after bad accesses", last_x, last_y, last_st, last_spd);

		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* tests/platform_vectors.txt */
# key(hex) steps x y state speed, expected POS and STATUS after the last of the steps
# state 0 grounded, 1 rising, 2 falling; speed is the fall speed field of STATUS
00000000 1 30 34 2 1
00000000 1 30 36 2 2
00000000 1 30 39 2 3
00000000 1 30 43 2 4
00000000 1 30 48 2 5
00000000 1 30 53 2 6
00000000 59 30 348 2 6
00000000 1 30 351 2 6
00000000 1 30 351 0 0
00000000 1 30 351 0 0
00000007 208 446 351 0 0
00000007 1 447 351 0 0
00000007 1 447 351 0 0
00000004 1 445 351 0 0
00000004 210 25 351 0 0
00000004 1 25 351 0 0
0000001A 1 25 351 1 0
0000001A 7 25 323 1 0
0000001A 1 25 319 2 0
0000001A 1 25 320 2 1
00000000 4 25 334 2 5
00000000 4 25 351 2 6
00000000 1 25 351 0 0
00001A07 1 27 351 1 0
00001A07 8 43 319 2 0
0000071A 1 45 320 2 1
00000000 8 45 351 2 6
00000000 1 45 351 0 0
0000041A 1 43 351 1 0
00001A04 8 27 319 2 0
00001234 9 27 351 2 6
00000000 1 27 351 0 0

/* vlog.f */
hw/platform_pkg.sv
hw/apb_regs.sv
hw/collision_probe.sv
hw/motion_ctrl.sv
hw/pixel_shader.sv
hw/platform_top.sv
tests/platform_tb.sv
